/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_mem_subsys
RTL_TOP   = mem_subsys_top
FILELIST  = project.f
OBJ_DIR   = obj_dir
PASS_MSG  = STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

/* include/mem_settings.svh */
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// one cache line as moved between the ports and the store
`define MEM_LINE_W 256

// line address, the byte offset is already stripped
`define MEM_TAG_W 27

// number of lines in the backing store, indexed by the low tag bits
`define MEM_STORE_DEPTH 16

// cycles from a sampled store request to its response, at least 2
`define MEM_STORE_LAT 4

// number of random operations issued by the testbench
`define MEM_TB_NUM_OPS 200

`endif

/* project.f */
+incdir+include
src/mem_pkg.sv
src/line_buffer.sv
src/l2_arbiter.sv
src/line_store.sv
src/mem_subsys_top.sv
sim/tb_clock.sv
sim/tb_mem_subsys.sv

/* sim/tb_clock.sv */
module tb_clock (
  output logic clk_o,
  output logic rst_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD  = 5;
  localparam int RESET_CYCLES = 5;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // release just after an edge so the DUT sees a clean reset window
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rst_o = 1'b0;
  end

endmodule

/* sim/tb_mem_subsys.sv */
`include "mem_settings.svh"

module tb_mem_subsys;
  timeunit 1ns;
  timeprecision 100ps;
  import mem_pkg::*;

  localparam int NUM_DIRECTED   = 8;
  localparam int HALF_OPS       = `MEM_TB_NUM_OPS / 2;
  localparam int TIMEOUT_CYCLES = (`MEM_TB_NUM_OPS + NUM_DIRECTED) * (2 * `MEM_STORE_LAT + 8);
  localparam int IDX_W          = $bits(mem_index_t);

  logic      clk;
  logic      rst;
  mem_tag_t  inst_tag;
  logic      inst_read;
  logic      inst_write;
  mem_line_t inst_wline;
  mem_line_t inst_rline;
  logic      inst_resp;
  mem_tag_t  data_tag;
  logic      data_read;
  logic      data_write;
  mem_line_t data_wline;
  mem_line_t data_rline;
  logic      data_resp;

  // transfer in flight per port
  // index 0 is inst and 1 is data
  logic      busy [2] = '{1'b0, 1'b0};
  logic      op_write [2];
  mem_tag_t  op_tag [2];
  mem_line_t op_line [2];
  int        issue_cycle [2];
  int        resp_cycle [2] = '{0, 0};
  int        resp_count [2] = '{0, 0};
  int        issued_count = 0;

  // model of both line buffers and of the store
  logic      buf_valid [2] = '{1'b0, 1'b0};
  mem_tag_t  buf_tag [2];
  mem_line_t buf_line [2];
  mem_line_t store_model [`MEM_STORE_DEPTH] = '{default: '0};

  // random stimulus drawn up front so both ports can run in parallel
  logic      rnd_write [2][HALF_OPS];
  mem_tag_t  rnd_tag [2][HALF_OPS];
  mem_line_t rnd_line [2][HALF_OPS];
  int        rnd_gap [2][HALF_OPS];

  int cycle       = 0;
  int check_count = 0;
  int error_count = 0;

  tb_clock u_clock (
    .clk_o (clk),
    .rst_o (rst)
  );

  mem_subsys_top UUT (
    .clk          (clk),
    .rst          (rst),
    .inst_tag_i   (inst_tag),
    .inst_read_i  (inst_read),
    .inst_write_i (inst_write),
    .inst_wline_i (inst_wline),
    .inst_rline_o (inst_rline),
    .inst_resp_o  (inst_resp),
    .data_tag_i   (data_tag),
    .data_read_i  (data_read),
    .data_write_i (data_write),
    .data_wline_i (data_wline),
    .data_rline_o (data_rline),
    .data_resp_o  (data_resp)
  );

  // a buffered tag answers from the port's own line and any other tag from the store
  function automatic mem_line_t expected_read_line(input int port, input mem_tag_t tag);
    mem_index_t idx;
    mem_line_t  result;
    idx = tag[IDX_W-1:0];
    result = store_model[idx];
    if (buf_valid[port] && buf_tag[port] == tag) begin
      result = buf_line[port];
    end
    return result;
  endfunction

  function automatic mem_line_t random_line();
    mem_line_t value;
    for (int w = 0; w < `MEM_LINE_W / 32; w++) begin
      value[w*32 +: 32] = $urandom;
    end
    return value;
  endfunction

  function automatic logic port_resp(input int port);
    return (port == 0) ? inst_resp : data_resp;
  endfunction

  task automatic check_equal(input string name, input mem_line_t got, input mem_line_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error: %s got %0h expected %0h", name, got, exp);
    end
  endtask

  task automatic report_counts();
    $display("summary: %0d checks, %0d errors, %0d inst responses, %0d data responses",
             check_count, error_count, resp_count[0], resp_count[1]);
  endtask

  task automatic record_response(input int port, input mem_line_t line);
    string      pname;
    mem_index_t idx;
    mem_line_t  exp;
    pname = (port == 0) ? "inst" : "data";
    idx = op_tag[port][IDX_W-1:0];
    check_equal({pname, "_resp_o"}, mem_line_t'(1), mem_line_t'(busy[port]));
    resp_cycle[port] = cycle;
    resp_count[port]++;
    if (op_write[port]) begin
      store_model[idx] = op_line[port];
      buf_line[port] = op_line[port];
    end else begin
      exp = expected_read_line(port, op_tag[port]);
      check_equal({pname, "_rline_o"}, line, exp);
      buf_line[port] = exp;
    end
    buf_valid[port] = 1'b1;
    buf_tag[port] = op_tag[port];
  endtask

  task automatic drive_port(input int port, input logic rd, input logic wr,
                            input mem_tag_t tag, input mem_line_t line);
    if (port == 0) begin
      inst_tag   = tag;
      inst_wline = line;
      inst_read  = rd;
      inst_write = wr;
    end else begin
      data_tag   = tag;
      data_wline = line;
      data_read  = rd;
      data_write = wr;
    end
  endtask

  // called 1 ns after a rising edge and returns at the same point of a later cycle
  task automatic run_op(input int port, input logic is_write, input mem_tag_t tag,
                        input mem_line_t line);
    op_write[port] = is_write;
    op_tag[port] = tag;
    op_line[port] = line;
    busy[port] = 1'b1;
    issue_cycle[port] = cycle;
    issued_count++;
    drive_port(port, !is_write, is_write, tag, line);
    @(negedge clk);
    while (!port_resp(port)) @(negedge clk);
    @(posedge clk);
    #1;
    drive_port(port, 1'b0, 1'b0, tag, line);
    busy[port] = 1'b0;
    // let the buffer leave DONE before the next request
    @(posedge clk);
    #1;
  endtask

  task automatic run_port_sequence(input int port);
    for (int i = 0; i < HALF_OPS; i++) begin
      repeat (rnd_gap[port][i]) begin
        @(posedge clk);
        #1;
      end
      run_op(port, rnd_write[port][i], rnd_tag[port][i], rnd_line[port][i]);
    end
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
      report_counts();
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // responses are sampled at the falling edge where the outputs are stable
  always @(negedge clk) begin
    if (!rst) begin
      if (inst_resp) begin
        record_response(0, inst_rline);
      end
      if (data_resp) begin
        record_response(1, data_rline);
      end
    end
  end

  initial begin
    int          latency;
    mem_line_t   line_a;
    mem_line_t   line_b;
    void'($urandom(32'h5342));
    drive_port(0, 1'b0, 1'b0, '0, '0);
    drive_port(1, 1'b0, 1'b0, '0, '0);

    // tags share store indices 0 to 3 so different tags alias
    for (int p = 0; p < 2; p++) begin
      for (int i = 0; i < HALF_OPS; i++) begin
        rnd_write[p][i] = ($urandom % 2) == 1;
        rnd_tag[p][i]   = mem_tag_t'((($urandom % 3) << IDX_W) | ($urandom % 4));
        rnd_line[p][i]  = random_line();
        rnd_gap[p][i]   = int'($urandom % 3);
      end
    end

    wait (rst == 1'b0);
    @(posedge clk);
    #1;

    // quiet ports after reset
    repeat (20) begin
      @(posedge clk);
      #1;
    end
    check_equal("resp_count", mem_line_t'(resp_count[0] + resp_count[1]), '0);

    // data write then a read of the same tag served by the buffer
    line_a = random_line();
    run_op(1, 1'b1, 27'h005, line_a);
    run_op(1, 1'b0, 27'h005, '0);
    latency = resp_cycle[1] - issue_cycle[1];
    check_equal("data_hit_latency", mem_line_t'(latency < `MEM_STORE_LAT), mem_line_t'(1));

    // an untouched tag reads zero and an inst write is seen by a data read
    run_op(1, 1'b0, 27'h0a7, '0);
    line_b = random_line();
    run_op(0, 1'b1, 27'h033, line_b);
    run_op(1, 1'b0, 27'h033, '0);

    // both ports in the same cycle
    fork
      run_op(0, 1'b0, 27'h044, '0);
      run_op(1, 1'b0, 27'h155, '0);
    join
    check_equal("inst_resp_first", mem_line_t'(resp_cycle[0] < resp_cycle[1]), mem_line_t'(1));

    fork
      run_port_sequence(0);
      run_port_sequence(1);
    join

    repeat (4) begin
      @(posedge clk);
      #1;
    end
    check_equal("response_count", mem_line_t'(resp_count[0] + resp_count[1]),
                mem_line_t'(issued_count));

    report_counts();
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* src/l2_arbiter.sv */
module l2_arbiter (
  input  logic               clk,
  input  logic               rst,
  input  mem_pkg::mem_tag_t  inst_tag_i,
  input  logic               inst_read_i,
  input  logic               inst_write_i,
  input  mem_pkg::mem_line_t inst_line_i,
  input  mem_pkg::mem_tag_t  data_tag_i,
  input  logic               data_read_i,
  input  logic               data_write_i,
  input  mem_pkg::mem_line_t data_line_i,
  output mem_pkg::mem_line_t inst_line_o,
  output logic               inst_resp_o,
  output mem_pkg::mem_line_t data_line_o,
  output logic               data_resp_o,
  input  logic               mem_resp_i,
  input  mem_pkg::mem_line_t mem_line_i,
  output mem_pkg::mem_line_t mem_line_o,
  output logic               mem_read_o,
  output logic               mem_write_o,
  output mem_pkg::mem_tag_t  mem_tag_o
);
  import mem_pkg::*;

  arb_state_t state;
  arb_state_t state_next;

  logic inst_req;
  logic data_req;
  logic grant;
  // 1 while the instruction port owns the store
  logic owner_inst;
  logic resp_hit;

  assign inst_req = inst_read_i || inst_write_i;
  assign data_req = data_read_i || data_write_i;
  assign grant    = (state == ARB_IDLE) && (inst_req || data_req);
  assign resp_hit = (state == ARB_WAIT) && mem_resp_i;

  always_comb begin
    state_next = state;
    unique case (state)
      ARB_IDLE: begin
        if (inst_req || data_req) begin
          state_next = ARB_WAIT;
        end
      end
      ARB_WAIT: begin
        if (mem_resp_i) begin
          state_next = ARB_IDLE;
        end
      end
      default: begin
        state_next = ARB_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= ARB_IDLE;
      owner_inst  <= 1'b0;
      mem_read_o  <= 1'b0;
      mem_write_o <= 1'b0;
    end else begin
      state <= state_next;
      // instruction side wins a tie
      if (grant) begin
        owner_inst  <= inst_req;
        mem_read_o  <= inst_req ? inst_read_i : data_read_i;
        mem_write_o <= inst_req ? inst_write_i : data_write_i;
      end else if (resp_hit) begin
        mem_read_o  <= 1'b0;
        mem_write_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grant) begin
      mem_tag_o  <= inst_req ? inst_tag_i : data_tag_i;
      mem_line_o <= inst_req ? inst_line_i : data_line_i;
    end
  end

  // only the owner sees the store's answer
  assign inst_resp_o = resp_hit && owner_inst;
  assign data_resp_o = resp_hit && !owner_inst;
  assign inst_line_o = (state == ARB_WAIT && owner_inst) ? mem_line_i : '0;
  assign data_line_o = (state == ARB_WAIT && !owner_inst) ? mem_line_i : '0;

endmodule

/* src/line_buffer.sv */
module line_buffer (
  input  logic               clk,
  input  logic               rst,
  input  mem_pkg::mem_tag_t  tag_i,
  input  logic               read_i,
  input  logic               write_i,
  input  mem_pkg::mem_line_t wline_i,
  output mem_pkg::mem_line_t rline_o,
  output logic               resp_o,
  output mem_pkg::mem_tag_t  req_tag_o,
  output logic               req_read_o,
  output logic               req_write_o,
  output mem_pkg::mem_line_t req_line_o,
  input  logic               arb_resp_i,
  input  mem_pkg::mem_line_t arb_line_i
);
  import mem_pkg::*;

  lb_state_t state;
  lb_state_t state_next;

  // the single buffered line
  logic      valid_q;
  mem_tag_t  tag_q;
  mem_line_t line_q;

  logic hit;
  logic accept_fwd;
  logic fwd_done;

  assign hit = valid_q && (tag_q == tag_i);

  always_comb begin
    state_next = state;
    unique case (state)
      LB_READY: begin
        if (write_i) begin
          state_next = LB_FORWARD;
        end else if (read_i && hit) begin
          state_next = LB_HIT;
        end else if (read_i) begin
          state_next = LB_FORWARD;
        end
      end
      LB_HIT: begin
        state_next = LB_DONE;
      end
      LB_FORWARD: begin
        if (arb_resp_i) begin
          state_next = LB_DONE;
        end
      end
      // client drops its level on the edge after resp
      LB_DONE: begin
        state_next = LB_READY;
      end
      default: begin
        state_next = LB_READY;
      end
    endcase
  end

  assign accept_fwd = (state == LB_READY) && (state_next == LB_FORWARD);
  assign fwd_done   = (state == LB_FORWARD) && arb_resp_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= LB_READY;
      valid_q     <= 1'b0;
      req_read_o  <= 1'b0;
      req_write_o <= 1'b0;
    end else begin
      state <= state_next;
      if (accept_fwd) begin
        req_read_o  <= !write_i;
        req_write_o <= write_i;
      end else if (fwd_done) begin
        req_read_o  <= 1'b0;
        req_write_o <= 1'b0;
        valid_q     <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept_fwd) begin
      req_tag_o  <= tag_i;
      req_line_o <= wline_i;
    end
    // a finished transfer refills the buffer, writes keep their own data
    if (fwd_done) begin
      tag_q  <= req_tag_o;
      line_q <= req_write_o ? req_line_o : arb_line_i;
    end
  end

  assign resp_o  = (state == LB_HIT) || fwd_done;
  assign rline_o = (state == LB_FORWARD) ? arb_line_i : line_q;

endmodule

/* src/line_store.sv */
`include "mem_settings.svh"

module line_store (
  input  logic               clk,
  input  logic               rst,
  input  logic               read_i,
  input  logic               write_i,
  input  mem_pkg::mem_tag_t  tag_i,
  input  mem_pkg::mem_line_t line_i,
  output mem_pkg::mem_line_t line_o,
  output logic               resp_o
);
  import mem_pkg::*;

  localparam int unsigned CNT_W = $clog2(`MEM_STORE_LAT);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`MEM_STORE_LAT - 2);

  store_state_t state;
  mem_line_t    mem_q [`MEM_STORE_DEPTH];
  mem_index_t   idx;
  logic [CNT_W-1:0] cnt_q;

  assign idx = tag_i[$bits(mem_index_t)-1:0];

  // tag and line stay stable in the arbiter until resp
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      cnt_q <= '0;
      for (int i = 0; i < `MEM_STORE_DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      unique case (state)
        ST_IDLE: begin
          cnt_q <= '0;
          if (read_i || write_i) begin
            state <= ST_BUSY;
          end
        end
        ST_BUSY: begin
          if (cnt_q == CNT_LAST) begin
            state <= ST_RESP;
            if (write_i) begin
              mem_q[idx] <= line_i;
            end
          end else begin
            cnt_q <= cnt_q + CNT_W'(1);
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // writes echo their own line back
  always_ff @(posedge clk) begin
    if (state == ST_BUSY && cnt_q == CNT_LAST) begin
      line_o <= write_i ? line_i : mem_q[idx];
    end
  end

  assign resp_o = (state == ST_RESP);

endmodule

/* src/mem_pkg.sv */
`include "mem_settings.svh"

package mem_pkg;

  typedef logic [`MEM_LINE_W-1:0] mem_line_t;
  typedef logic [`MEM_TAG_W-1:0] mem_tag_t;

  // store index, taken from the low bits of a tag
  typedef logic [$clog2(`MEM_STORE_DEPTH)-1:0] mem_index_t;

  typedef enum logic {
    ARB_IDLE,
    ARB_WAIT
  } arb_state_t;

  typedef enum logic [1:0] {
    LB_READY,
    LB_HIT,
    LB_FORWARD,
    LB_DONE
  } lb_state_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_RESP
  } store_state_t;

endpackage

/* src/mem_subsys_top.sv */
module mem_subsys_top (
  input  logic               clk,
  input  logic               rst,
  input  mem_pkg::mem_tag_t  inst_tag_i,
  input  logic               inst_read_i,
  input  logic               inst_write_i,
  input  mem_pkg::mem_line_t inst_wline_i,
  output mem_pkg::mem_line_t inst_rline_o,
  output logic               inst_resp_o,
  input  mem_pkg::mem_tag_t  data_tag_i,
  input  logic               data_read_i,
  input  logic               data_write_i,
  input  mem_pkg::mem_line_t data_wline_i,
  output mem_pkg::mem_line_t data_rline_o,
  output logic               data_resp_o
);
  import mem_pkg::*;

  // line buffer to arbiter, per port
  mem_tag_t  inst_req_tag;
  logic      inst_req_read;
  logic      inst_req_write;
  mem_line_t inst_req_line;
  logic      inst_arb_resp;
  mem_line_t inst_arb_line;

  mem_tag_t  data_req_tag;
  logic      data_req_read;
  logic      data_req_write;
  mem_line_t data_req_line;
  logic      data_arb_resp;
  mem_line_t data_arb_line;

  // arbiter to store
  mem_tag_t  mem_tag;
  logic      mem_read;
  logic      mem_write;
  mem_line_t mem_wline;
  mem_line_t mem_rline;
  logic      mem_resp;

  line_buffer u_inst_lb (
    .clk         (clk),
    .rst         (rst),
    .tag_i       (inst_tag_i),
    .read_i      (inst_read_i),
    .write_i     (inst_write_i),
    .wline_i     (inst_wline_i),
    .rline_o     (inst_rline_o),
    .resp_o      (inst_resp_o),
    .req_tag_o   (inst_req_tag),
    .req_read_o  (inst_req_read),
    .req_write_o (inst_req_write),
    .req_line_o  (inst_req_line),
    .arb_resp_i  (inst_arb_resp),
    .arb_line_i  (inst_arb_line)
  );

  line_buffer u_data_lb (
    .clk         (clk),
    .rst         (rst),
    .tag_i       (data_tag_i),
    .read_i      (data_read_i),
    .write_i     (data_write_i),
    .wline_i     (data_wline_i),
    .rline_o     (data_rline_o),
    .resp_o      (data_resp_o),
    .req_tag_o   (data_req_tag),
    .req_read_o  (data_req_read),
    .req_write_o (data_req_write),
    .req_line_o  (data_req_line),
    .arb_resp_i  (data_arb_resp),
    .arb_line_i  (data_arb_line)
  );

  l2_arbiter u_arbiter (
    .clk          (clk),
    .rst          (rst),
    .inst_tag_i   (inst_req_tag),
    .inst_read_i  (inst_req_read),
    .inst_write_i (inst_req_write),
    .inst_line_i  (inst_req_line),
    .data_tag_i   (data_req_tag),
    .data_read_i  (data_req_read),
    .data_write_i (data_req_write),
    .data_line_i  (data_req_line),
    .inst_line_o  (inst_arb_line),
    .inst_resp_o  (inst_arb_resp),
    .data_line_o  (data_arb_line),
    .data_resp_o  (data_arb_resp),
    .mem_resp_i   (mem_resp),
    .mem_line_i   (mem_rline),
    .mem_line_o   (mem_wline),
    .mem_read_o   (mem_read),
    .mem_write_o  (mem_write),
    .mem_tag_o    (mem_tag)
  );

  line_store u_store (
    .clk     (clk),
    .rst     (rst),
    .read_i  (mem_read),
    .write_i (mem_write),
    .tag_i   (mem_tag),
    .line_i  (mem_wline),
    .line_o  (mem_rline),
    .resp_o  (mem_resp)
  );

endmodule
